/* build.f */
design/datapathPkg.sv
design/instrDecode.sv
design/aluExecute.sv
design/resultWriteback.sv
design/datapathTop.sv
tests/datapathChecker.sv
tests/datapathTb.sv

/* run.sh */
#!/bin/sh
# compile with Verilator, run, then look for the pass line in the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module datapathTb -f build.f \
    > build.log 2>&1 &&
    ./obj_dir/VdatapathTb > sim.log 2>&1 ||
    echo "build or simulation did not complete, see build.log and sim.log"
grep -q '^>>> PASS$' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* tests/datapathTb.sv */
`timescale 1ns/1ns
module datapathTb;
    import datapathPkg::*;

    localparam int dataWidth = 32;
    localparam int regCount = 16;
    // every transfer fits well inside eight cycles
    localparam int transferCount = 160;
    localparam int cycleLimit = transferCount * 8 + 50;

    logic Clock;
    logic rst;
    logic [apbAddrWidth-1:0] paddr;
    logic psel;
    logic penable;
    logic pwrite;
    logic [dataWidth-1:0] pwdata;
    logic [dataWidth-1:0] prdata;
    logic pready;
    logic pslverr;
    logic [dataWidth-1:0] expData;
    logic expErr;
    int expWait;
    int errorCount;
    int checkCount;

    logic [dataWidth-1:0] regModel [regCount];
    logic [dataWidth-1:0] hiModel;
    logic [dataWidth-1:0] loModel;
    integer seed = 32'h43907de4;
    int cycleCount = 0;
    int errorsAtStart = 0;
    int passCount = 0;
    int failCount = 0;

    datapathTop #(
        .dataWidth(dataWidth),
        .regCount(regCount)
    ) datapathTop_i (
        .Clock(Clock),
        .rst(rst),
        .paddr(paddr),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr)
    );

    datapathChecker #(
        .dataWidth(dataWidth)
    ) datapathChecker_i (
        .Clock(Clock),
        .rst(rst),
        .paddr(paddr),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .expData(expData),
        .expErr(expErr),
        .expWait(expWait),
        .errorCount(errorCount),
        .checkCount(checkCount)
    );

    always #2 Clock = ~Clock;

    always @(posedge Clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: the run passed %0d cycles, a transfer never completed", cycleLimit);
            $display(">>> FAIL");
            $finish;
        end
    end

    // expected destination value or {HI, LO} for mul
    function automatic logic [2*dataWidth-1:0] refResult(input aluOp code,
                                                         input logic [dataWidth-1:0] b,
                                                         input logic [dataWidth-1:0] c);
        int amt;
        logic [2*dataWidth-1:0] res;
        logic [2*dataWidth-1:0] wideB;
        logic [2*dataWidth-1:0] wideC;
        amt = c % dataWidth;
        wideB = b;
        wideC = c;
        res = '0;
        case (code)
            opAdd: res[dataWidth-1:0] = b + c;
            opSub: res[dataWidth-1:0] = b + ~c + 1'b1;
            opAnd: res[dataWidth-1:0] = b & c;
            opOr:  res[dataWidth-1:0] = b | c;
            opShr: res[dataWidth-1:0] = b >> amt;
            opShl: res[dataWidth-1:0] = b << amt;
            opRor: res[dataWidth-1:0] = (b >> amt) | (b << (dataWidth - amt));
            opRol: res[dataWidth-1:0] = (b << amt) | (b >> (dataWidth - amt));
            opMul: res = wideB * wideC;
            opNeg: res[dataWidth-1:0] = ~b + 1'b1;
            opNot: res[dataWidth-1:0] = ~b;
            default: res = '0;
        endcase
        return res;
    endfunction

    function automatic logic [apbAddrWidth-1:0] regAddr(input logic [3:0] idx);
        return addrRegBase + apbAddrWidth'(4 * idx);
    endfunction

    // one APB transfer with its expectations posted to the checker
    task automatic apbTransfer(input logic write, input logic [apbAddrWidth-1:0] addr,
                               input logic [dataWidth-1:0] data,
                               input logic [dataWidth-1:0] expValue,
                               input logic errExp, input int waitExp);
        @(posedge Clock);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= write;
        paddr <= addr;
        pwdata <= data;
        expData <= expValue;
        expErr <= errExp;
        expWait <= waitExp;
        @(posedge Clock);
        penable <= 1'b1;
        @(negedge Clock);
        while (!pready) begin
            @(negedge Clock);
        end
        @(posedge Clock);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic regWrite(input logic [3:0] idx, input logic [dataWidth-1:0] value);
        apbTransfer(1'b1, regAddr(idx), value, '0, 1'b0, 0);
        regModel[idx] = value;
    endtask

    task automatic regRead(input logic [3:0] idx);
        apbTransfer(1'b0, regAddr(idx), '0, regModel[idx], 1'b0, 0);
    endtask

    task automatic hiLoRead();
        apbTransfer(1'b0, addrHi, '0, hiModel, 1'b0, 0);
        apbTransfer(1'b0, addrLo, '0, loModel, 1'b0, 0);
    endtask

    task automatic allRegsRead();
        for (int i = 0; i < regCount; i++) begin
            regRead(4'(i));
        end
    endtask

    task automatic issueOp(input aluOp code, input logic [3:0] ra, input logic [3:0] rb,
                           input logic [3:0] rc);
        logic [2*dataWidth-1:0] expected;
        expected = refResult(code, regModel[rb], regModel[rc]);
        apbTransfer(1'b1, addrInstr, {code, ra, rb, rc, 15'd0}, '0, 1'b0, 3);
        if (code == opMul) begin
            hiModel = expected[2*dataWidth-1:dataWidth];
            loModel = expected[dataWidth-1:0];
        end else begin
            regModel[ra] = expected[dataWidth-1:0];
        end
    endtask

    // random registers with rb and rc kept apart
    task automatic runOp(input aluOp code, input logic [dataWidth-1:0] bVal,
                         input logic [dataWidth-1:0] cVal);
        logic [3:0] ra;
        logic [3:0] rb;
        logic [3:0] rc;
        rb = 4'($random(seed));
        rc = rb + 4'd7;
        ra = 4'($random(seed));
        regWrite(rb, bVal);
        regWrite(rc, cVal);
        issueOp(code, ra, rb, rc);
        if (code == opMul) begin
            hiLoRead();
        end
        regRead(ra);
    endtask

    task automatic finishTest(input string name);
        int newErrors;
        newErrors = errorCount - errorsAtStart;
        if (newErrors == 0) begin
            passCount++;
            $display("test %s: passed", name);
        end else begin
            failCount++;
            $display("test %s: failed with %0d errors", name, newErrors);
        end
        errorsAtStart = errorCount;
    endtask

    initial begin
        Clock = 1'b0;
        rst = 1'b1;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        expData = '0;
        expErr = 1'b0;
        expWait = 0;
        for (int i = 0; i < regCount; i++) begin
            regModel[i] = '0;
        end
        hiModel = '0;
        loModel = '0;
        repeat (3) @(posedge Clock);
        rst <= 1'b0;

        allRegsRead();
        hiLoRead();
        finishTest("reset");

        for (int i = 0; i < regCount; i++) begin
            regWrite(4'(i), $random(seed));
        end
        allRegsRead();
        finishTest("register load and readback");

        regWrite(4'd6, 32'h12);
        regWrite(4'd4, 32'h14);
        regWrite(4'd6, 32'h18);
        issueOp(opRol, 4'd6, 4'd6, 4'd4);
        regRead(4'd6);
        runOp(opAdd, $random(seed), $random(seed));
        runOp(opSub, $random(seed), $random(seed));
        runOp(opAnd, $random(seed), $random(seed));
        runOp(opOr, $random(seed), $random(seed));
        runOp(opShr, $random(seed), $random(seed));
        runOp(opShl, $random(seed), $random(seed));
        runOp(opRor, $random(seed), $random(seed));
        runOp(opRol, $random(seed), $random(seed));
        runOp(opNeg, $random(seed), $random(seed));
        runOp(opNot, $random(seed), $random(seed));
        // amounts 0 and 31 both plain and with upper bits set
        runOp(opRor, $random(seed), 32'h0000_0020);
        runOp(opRol, $random(seed), 32'd31);
        runOp(opRol, $random(seed), 32'd0);
        runOp(opRor, $random(seed), 32'hffff_ffff);
        finishTest("reference sequence");

        runOp(opMul, $random(seed), $random(seed));
        runOp(opMul, 32'hffff_ffff, 32'hffff_ffff);
        finishTest("mul");

        runOp(opAdd, $random(seed), $random(seed));
        runOp(opShl, $random(seed), $random(seed));
        runOp(opSub, $random(seed), $random(seed));
        finishTest("instruction latency");

        apbTransfer(1'b1, addrInstr, {5'b11111, 4'd1, 4'd2, 4'd3, 15'd0}, '0, 1'b1, 0);
        apbTransfer(1'b1, addrInstr, {5'b00000, 4'd5, 4'd6, 4'd7, 15'd0}, '0, 1'b1, 0);
        allRegsRead();
        finishTest("illegal opcode");

        $display("tests %0d, passed %0d, failed %0d, transfers checked %0d, errors %0d",
                 passCount + failCount, passCount, failCount, checkCount, errorCount);
        if (failCount == 0 && errorCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* tests/datapathChecker.sv */
`timescale 1ns/1ns
module datapathChecker #(
    parameter int dataWidth = 32
) (
    input  logic Clock,
    input  logic rst,
    input  logic [datapathPkg::apbAddrWidth-1:0] paddr,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [dataWidth-1:0] prdata,
    input  logic pready,
    input  logic pslverr,
    input  logic [dataWidth-1:0] expData,
    input  logic expErr,
    input  int expWait,
    output int errorCount,
    output int checkCount
);
    int waitCycles = 0;
    int errors = 0;
    int checks = 0;

    assign errorCount = errors;
    assign checkCount = checks;

    // sampled mid-cycle, after the APB outputs have settled
    always @(negedge Clock) begin
        if (!rst) begin
            if (psel && penable) begin
                if (pready) begin
                    checks = checks + 1;
                    if (waitCycles != expWait) begin
                        errors = errors + 1;
                        $display("FAILED t=%0t pready wait cycles at paddr %h expected %0d got %0d",
                                 $time, paddr, expWait, waitCycles);
                    end
                    if (pslverr !== expErr) begin
                        errors = errors + 1;
                        $display("FAILED t=%0t pslverr at paddr %h expected %b got %b",
                                 $time, paddr, expErr, pslverr);
                    end
                    if (!pwrite && !expErr && prdata !== expData) begin
                        errors = errors + 1;
                        $display("FAILED t=%0t prdata at paddr %h expected %h got %h",
                                 $time, paddr, expData, prdata);
                    end
                    waitCycles = 0;
                end else begin
                    waitCycles = waitCycles + 1;
                end
            end else if (pready !== 1'b0) begin
                // idle bus must see pready low
                errors = errors + 1;
                $display("FAILED t=%0t pready outside an access phase expected 0 got %b",
                         $time, pready);
            end
        end
    end

endmodule

/* design/datapathTop.sv */
`timescale 1ns/1ns
module datapathTop #(
    parameter int dataWidth = 32,
    parameter int regCount = 16
) (
    input  logic Clock,
    input  logic rst,
    input  logic [datapathPkg::apbAddrWidth-1:0] paddr,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [dataWidth-1:0] pwdata,
    output logic [dataWidth-1:0] prdata,
    output logic pready,
    output logic pslverr
);
    import datapathPkg::*;

    // register file ports
    logic [regIdxWidth-1:0] rdIdxB;
    logic [regIdxWidth-1:0] rdIdxC;
    logic [regIdxWidth-1:0] rdIdxHost;
    logic [dataWidth-1:0] rdDataB;
    logic [dataWidth-1:0] rdDataC;
    logic [dataWidth-1:0] rdDataHost;
    logic [dataWidth-1:0] hiData;
    logic [dataWidth-1:0] loData;
    logic hostWrEn;
    logic [regIdxWidth-1:0] hostWrIdx;
    logic [dataWidth-1:0] hostWrData;

    // decode to execute
    logic issueValid;
    aluOp op;
    logic [regIdxWidth-1:0] dstIdx;
    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] opB;

    // execute to writeback
    logic resValid;
    aluOp resOp;
    logic [regIdxWidth-1:0] resDst;
    logic [dataWidth-1:0] result;
    logic [dataWidth-1:0] prodHi;
    logic wbDone;

    instrDecode #(
        .dataWidth(dataWidth),
        .regCount(regCount)
    ) instrDecode_i (
        .Clock(Clock),
        .rst(rst),
        .paddr(paddr),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .rdIdxB(rdIdxB),
        .rdIdxC(rdIdxC),
        .rdDataB(rdDataB),
        .rdDataC(rdDataC),
        .rdIdxHost(rdIdxHost),
        .rdDataHost(rdDataHost),
        .hiData(hiData),
        .loData(loData),
        .hostWrEn(hostWrEn),
        .hostWrIdx(hostWrIdx),
        .hostWrData(hostWrData),
        .issueValid(issueValid),
        .op(op),
        .dstIdx(dstIdx),
        .opA(opA),
        .opB(opB),
        .wbDone(wbDone)
    );

    aluExecute #(
        .dataWidth(dataWidth)
    ) aluExecute_i (
        .Clock(Clock),
        .rst(rst),
        .issueValid(issueValid),
        .op(op),
        .dstIdx(dstIdx),
        .opA(opA),
        .opB(opB),
        .resValid(resValid),
        .resOp(resOp),
        .resDst(resDst),
        .result(result),
        .prodHi(prodHi)
    );

    resultWriteback #(
        .dataWidth(dataWidth),
        .regCount(regCount)
    ) resultWriteback_i (
        .Clock(Clock),
        .rst(rst),
        .rdIdxB(rdIdxB),
        .rdIdxC(rdIdxC),
        .rdIdxHost(rdIdxHost),
        .rdDataB(rdDataB),
        .rdDataC(rdDataC),
        .rdDataHost(rdDataHost),
        .hostWrEn(hostWrEn),
        .hostWrIdx(hostWrIdx),
        .hostWrData(hostWrData),
        .resValid(resValid),
        .resOp(resOp),
        .resDst(resDst),
        .result(result),
        .prodHi(prodHi),
        .hiData(hiData),
        .loData(loData),
        .wbDone(wbDone)
    );

endmodule

/* design/resultWriteback.sv */
`timescale 1ns/1ns
module resultWriteback #(
    parameter int dataWidth = 32,
    parameter int regCount = 16
) (
    input  logic Clock,
    input  logic rst,
    input  logic [datapathPkg::regIdxWidth-1:0] rdIdxB,
    input  logic [datapathPkg::regIdxWidth-1:0] rdIdxC,
    input  logic [datapathPkg::regIdxWidth-1:0] rdIdxHost,
    output logic [dataWidth-1:0] rdDataB,
    output logic [dataWidth-1:0] rdDataC,
    output logic [dataWidth-1:0] rdDataHost,
    input  logic hostWrEn,
    input  logic [datapathPkg::regIdxWidth-1:0] hostWrIdx,
    input  logic [dataWidth-1:0] hostWrData,
    input  logic resValid,
    input  datapathPkg::aluOp resOp,
    input  logic [datapathPkg::regIdxWidth-1:0] resDst,
    input  logic [dataWidth-1:0] result,
    input  logic [dataWidth-1:0] prodHi,
    output logic [dataWidth-1:0] hiData,
    output logic [dataWidth-1:0] loData,
    output logic wbDone
);
    import datapathPkg::*;

    localparam int idxBits = $clog2(regCount);

    logic [dataWidth-1:0] regFile [regCount];
    logic [dataWidth-1:0] hiReg;
    logic [dataWidth-1:0] loReg;

    // indices past regCount read as zero
    assign rdDataB = (rdIdxB < regCount) ? regFile[rdIdxB[idxBits-1:0]] : '0;
    assign rdDataC = (rdIdxC < regCount) ? regFile[rdIdxC[idxBits-1:0]] : '0;
    assign rdDataHost = (rdIdxHost < regCount) ? regFile[rdIdxHost[idxBits-1:0]] : '0;

    assign hiData = hiReg;
    assign loData = loReg;

    always_ff @(posedge Clock) begin
        if (rst) begin
            for (int i = 0; i < regCount; i++)
                regFile[i] <= '0;
            hiReg <= '0;
            loReg <= '0;
            wbDone <= 1'b0;
        end else begin
            wbDone <= resValid;
            if (hostWrEn && hostWrIdx < regCount)
                regFile[hostWrIdx[idxBits-1:0]] <= hostWrData;
            if (resValid) begin
                // mul leaves the destination register alone
                if (resOp == opMul) begin
                    hiReg <= prodHi;
                    loReg <= result;
                end else if (resDst < regCount) begin
                    regFile[resDst[idxBits-1:0]] <= result;
                end
            end
        end
    end

    noWriteClash: assert property (@(posedge Clock) disable iff (rst)
        !(hostWrEn && resValid));

endmodule

/* design/aluExecute.sv */
`timescale 1ns/1ns
module aluExecute #(
    parameter int dataWidth = 32
) (
    input  logic Clock,
    input  logic rst,
    input  logic issueValid,
    input  datapathPkg::aluOp op,
    input  logic [datapathPkg::regIdxWidth-1:0] dstIdx,
    input  logic [dataWidth-1:0] opA,
    input  logic [dataWidth-1:0] opB,
    output logic resValid,
    output datapathPkg::aluOp resOp,
    output logic [datapathPkg::regIdxWidth-1:0] resDst,
    output logic [dataWidth-1:0] result,
    output logic [dataWidth-1:0] prodHi
);
    import datapathPkg::*;

    localparam int shiftWidth = $clog2(dataWidth);

    logic [shiftWidth-1:0] amount;
    logic [2*dataWidth-1:0] product;
    logic [2*dataWidth-1:0] rolWide;
    logic [2*dataWidth-1:0] rorWide;
    logic [dataWidth-1:0] nextResult;
    logic [dataWidth-1:0] nextHi;

    // shift amount is rc modulo dataWidth
    assign amount = opB[shiftWidth-1:0];

    // unsigned full-width product
    assign product = {{dataWidth{1'b0}}, opA} * {{dataWidth{1'b0}}, opB};

    // rotates via a doubled copy of the operand
    assign rolWide = {opA, opA} << amount;
    assign rorWide = {opA, opA} >> amount;

    always_comb begin
        nextHi = '0;
        case (op)
            opAdd:
                nextResult = opA + opB;
            opSub:
                nextResult = opA - opB;
            opAnd:
                nextResult = opA & opB;
            opOr:
                nextResult = opA | opB;
            opShr:
                nextResult = opA >> amount;
            opShl:
                nextResult = opA << amount;
            opRor:
                nextResult = rorWide[dataWidth-1:0];
            opRol:
                nextResult = rolWide[2*dataWidth-1 -: dataWidth];
            opMul: begin
                nextResult = product[dataWidth-1:0];
                nextHi = product[2*dataWidth-1:dataWidth];
            end
            opNeg:
                nextResult = '0 - opA;
            opNot:
                nextResult = ~opA;
            default:
                nextResult = '0;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (rst)
            resValid <= 1'b0;
        else
            resValid <= issueValid;
    end

    // execute stage payload
    always_ff @(posedge Clock) begin
        if (issueValid) begin
            result <= nextResult;
            prodHi <= nextHi;
            resOp <= op;
            resDst <= dstIdx;
        end
    end

    // each issue gives a single result pulse
    resultFollowsIssue: assert property (@(posedge Clock) disable iff (rst)
        issueValid |=> resValid ##1 !resValid);

endmodule

/* design/instrDecode.sv */
`timescale 1ns/1ns
module instrDecode #(
    parameter int dataWidth = 32,
    parameter int regCount = 16
) (
    input  logic Clock,
    input  logic rst,
    input  logic [datapathPkg::apbAddrWidth-1:0] paddr,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [dataWidth-1:0] pwdata,
    output logic [dataWidth-1:0] prdata,
    output logic pready,
    output logic pslverr,
    output logic [datapathPkg::regIdxWidth-1:0] rdIdxB,
    output logic [datapathPkg::regIdxWidth-1:0] rdIdxC,
    input  logic [dataWidth-1:0] rdDataB,
    input  logic [dataWidth-1:0] rdDataC,
    output logic [datapathPkg::regIdxWidth-1:0] rdIdxHost,
    input  logic [dataWidth-1:0] rdDataHost,
    input  logic [dataWidth-1:0] hiData,
    input  logic [dataWidth-1:0] loData,
    output logic hostWrEn,
    output logic [datapathPkg::regIdxWidth-1:0] hostWrIdx,
    output logic [dataWidth-1:0] hostWrData,
    output logic issueValid,
    output datapathPkg::aluOp op,
    output logic [datapathPkg::regIdxWidth-1:0] dstIdx,
    output logic [dataWidth-1:0] opA,
    output logic [dataWidth-1:0] opB,
    input  logic wbDone
);
    import datapathPkg::*;

    localparam logic [apbAddrWidth-1:0] regEnd = apbAddrWidth'(addrRegBase + 4 * regCount);

    logic [31:0] instrWord;
    logic [opcodeWidth-1:0] opField;
    logic [apbAddrWidth-1:0] regOffset;
    logic accessPhase;
    logic isInstr;
    logic isReg;
    logic isHi;
    logic isLo;
    logic badAccess;
    logic startInstr;
    logic instrLegal;
    logic busy;

    assign accessPhase = psel && penable;
    assign isInstr = (paddr == addrInstr);
    assign isReg = (paddr >= addrRegBase) && (paddr < regEnd) && (paddr[1:0] == 2'b00);
    assign isHi = (paddr == addrHi);
    assign isLo = (paddr == addrLo);
    // HI and LO are read only and the instruction port is write only
    assign badAccess = !(isInstr || isReg || isHi || isLo)
                       || (pwrite && (isHi || isLo)) || (!pwrite && isInstr);

    assign regOffset = paddr - addrRegBase;
    assign rdIdxHost = regOffset[regIdxWidth+1:2];

    // instruction fields
    assign instrWord = 32'(pwdata);
    assign opField = instrWord[opcodeLsb +: opcodeWidth];
    assign rdIdxB = instrWord[rbLsb +: regIdxWidth];
    assign rdIdxC = instrWord[rcLsb +: regIdxWidth];
    assign instrLegal = isLegalOp(opField);
    assign startInstr = accessPhase && !busy && pwrite && isInstr;

    assign hostWrEn = accessPhase && !busy && pwrite && isReg;
    assign hostWrIdx = rdIdxHost;
    assign hostWrData = pwdata;

    always_comb begin
        if (busy) begin
            // waiting on the three-stage pipe
            pready = accessPhase && wbDone;
            pslverr = 1'b0;
        end else if (startInstr && instrLegal) begin
            pready = 1'b0;
            pslverr = 1'b0;
        end else begin
            pready = accessPhase;
            pslverr = accessPhase && (badAccess || (startInstr && !instrLegal));
        end
    end

    always_comb begin
        if (isHi)
            prdata = hiData;
        else if (isLo)
            prdata = loData;
        else if (isReg)
            prdata = rdDataHost;
        else
            prdata = '0;
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            busy <= 1'b0;
            issueValid <= 1'b0;
        end else begin
            issueValid <= startInstr && instrLegal;
            if (startInstr && instrLegal)
                busy <= 1'b1;
            else if (busy && wbDone)
                busy <= 1'b0;
        end
    end

    // decode stage latch
    always_ff @(posedge Clock) begin
        if (startInstr && instrLegal) begin
            opA <= rdDataB;
            opB <= rdDataC;
            op <= aluOp'(opField);
            dstIdx <= instrWord[raLsb +: regIdxWidth];
        end
    end

    // pready returns two cycles after the issue pulse
    instrReadyLatency: assert property (@(posedge Clock) disable iff (rst)
        issueValid |-> !pready ##1 !pready ##1 pready);

    issueOnePulse: assert property (@(posedge Clock) disable iff (rst)
        issueValid |=> !issueValid);

endmodule

/* design/datapathPkg.sv */
package datapathPkg;

    // opcodes kept from the reference instruction set
    typedef enum logic [4:0] {
        opAdd = 5'b00011,
        opSub = 5'b00100,
        opAnd = 5'b00101,
        opOr  = 5'b00110,
        opShr = 5'b00111,
        opShl = 5'b01000,
        opRor = 5'b01001,
        opRol = 5'b01010,
        opMul = 5'b01011,
        opNeg = 5'b01100,
        opNot = 5'b01101
    } aluOp;

    localparam int opcodeWidth = 5;
    localparam int regIdxWidth = 4;

    // low bit of each instruction field
    localparam int opcodeLsb = 27;
    localparam int raLsb = 23;
    localparam int rbLsb = 19;
    localparam int rcLsb = 15;

    // APB address map
    localparam int apbAddrWidth = 12;
    localparam logic [apbAddrWidth-1:0] addrInstr = 12'h000;
    localparam logic [apbAddrWidth-1:0] addrRegBase = 12'h040;
    localparam logic [apbAddrWidth-1:0] addrHi = 12'h080;
    localparam logic [apbAddrWidth-1:0] addrLo = 12'h084;

    function automatic logic isLegalOp(logic [opcodeWidth-1:0] code);
        logic legal;
        case (code)
            opAdd, opSub, opAnd, opOr, opShr, opShl,
            opRor, opRol, opMul, opNeg, opNot: legal = 1'b1;
            default: legal = 1'b0;
        endcase
        return legal;
    endfunction

endpackage
